//--- logic/nocPkg.sv
package nocPkg;

  // --------------------------------------------------
  // sizes
  // --------------------------------------------------
  localparam int NumPorts = 5;
  localparam int LengthWidth = 12;   // width of the hold limit in a head flit.
  localparam int PayloadWidth = 16;

  // --------------------------------------------------
  // flit and port encodings
  // --------------------------------------------------

  // only a head flit matters to the arbiter, it carries the hold limit.
  typedef enum logic [2:0]
  {
    Head = 3'd1,
    Body = 3'd2,
    Tail = 3'd3
  } flitKind_t;

  typedef enum logic [2:0]
  {
    Local = 3'd0,
    North = 3'd1,
    East  = 3'd2,
    West  = 3'd3,
    South = 3'd4
  } portId_t;

  typedef struct packed
  {
    flitKind_t               kind;
    logic [LengthWidth-1:0]  length;
    logic [PayloadWidth-1:0] payload;
  } flit_t;

  // word on the output link, tagged with the channel it came from.
  typedef struct packed
  {
    portId_t srcPort;
    flit_t   flit;
  } linkFlit_t;

  // one-hot arbiter state.
  // bit 0 is idle, bits 1 to 5 follow the portId_t order.
  typedef logic [NumPorts:0] grant_t;

  localparam grant_t GrantIdle = grant_t'(1);

endpackage

//--- logic/inputBuffer.sv
module inputBuffer #(
  parameter int BufferDepth = 8
) (
  input  logic          clk,
  input  logic          rst,
  input  logic          push,
  input  nocPkg::flit_t inFlit,
  input  logic          pop,
  output nocPkg::flit_t headFlit,
  output logic          notEmpty,
  output logic          full
);

  localparam int PtrWidth = $clog2(BufferDepth);

  nocPkg::flit_t mem [BufferDepth];

  logic [PtrWidth-1:0] wrPtr;
  logic [PtrWidth-1:0] rdPtr;
  logic [PtrWidth:0]   count;   // one bit wider than the pointers to tell full from empty.
  logic                doPush;
  logic                doPop;

  // a push into a full buffer is lost, a pop from an empty one does nothing.
  assign doPush = push && !full;
  assign doPop = pop && notEmpty;

  assign notEmpty = (count != '0);
  assign full = (count == (PtrWidth + 1)'(BufferDepth));

  // the head is read straight from storage.
  assign headFlit = mem[rdPtr];

  // --------------------------------------------------
  // storage
  // --------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (doPush)
    begin
      mem[wrPtr] <= inFlit;
    end
  end

  // --------------------------------------------------
  // pointers and occupancy
  // --------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (doPush)
      begin
        wrPtr <= wrPtr + 1'b1;   // wraps on its own, the depth is a power of two.
      end
      if (doPop)
      begin
        rdPtr <= rdPtr + 1'b1;
      end
      case ({doPush, doPop})
        2'b10:
        begin
          count <= count + 1'b1;
        end
        2'b01:
        begin
          count <= count - 1'b1;
        end
        default:
        begin
          count <= count;   // both or neither leaves the level unchanged.
        end
      endcase
    end
  end

endmodule

//--- logic/holdTimer.sv
module holdTimer (
  input  logic          clk,
  input  logic          rst,
  input  nocPkg::flit_t headFlit,
  input  logic          run,
  output logic          timeUp
);

  logic [nocPkg::LengthWidth-1:0] limit;
  logic [nocPkg::LengthWidth-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      // a head flit waiting at the buffer front sets the limit for its packet.
      if (headFlit.kind == nocPkg::Head)
      begin
        limit <= headFlit.length;
      end
      if (run)
      begin
        count <= count + 1'b1;
      end
      else
      begin
        count <= '0;
      end
    end
  end

  // the channel gets limit+1 cycles on the link before this fires.
  assign timeUp = (count == limit);

endmodule

//--- logic/outputArbiter.sv
module outputArbiter (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [nocPkg::NumPorts-1:0] request,
  input  nocPkg::flit_t               headFlit [nocPkg::NumPorts],
  output nocPkg::grant_t              grant
);

  localparam int NumPorts = nocPkg::NumPorts;

  nocPkg::grant_t      state;
  nocPkg::grant_t      nextState;
  logic [2:0]          holder;    // channel that owns the link, meaningless while idle.
  logic [NumPorts-1:0] run;
  logic [NumPorts-1:0] timeUp;

  // --------------------------------------------------
  // hold timers
  // --------------------------------------------------
  for (genvar p = 0; p < NumPorts; p++)
  begin : gTimer
    holdTimer i_holdTimer (
      .clk      (clk),
      .rst      (rst),
      .headFlit (headFlit[p]),
      .run      (run[p]),
      .timeUp   (timeUp[p])
    );
  end

  // --------------------------------------------------
  // state register
  // --------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= nocPkg::GrantIdle;
    end
    else
    begin
      state <= nextState;
    end
  end

  assign grant = state;

  // turn the one-hot state into a channel number.
  always_comb
  begin
    holder = '0;
    for (int p = 0; p < NumPorts; p++)
    begin
      if (state[p + 1])
      begin
        holder = 3'(p);
      end
    end
  end

  // --------------------------------------------------
  // next state
  // --------------------------------------------------
  always_comb
  begin : nextStateLogic
    int unsigned cand;
    logic        found;

    nextState = nocPkg::GrantIdle;
    run = '0;
    found = 1'b0;

    // the owner keeps the link while it has flits and time left.
    if (!state[0] && request[holder] && !timeUp[holder])
    begin
      run[holder] = 1'b1;
      nextState = state;
      found = 1'b1;
    end

    // from idle the search runs L, N, E, W, S. Otherwise it starts after
    // the owner and reaches the owner itself last.
    for (int i = 1; i <= NumPorts; i++)
    begin
      cand = state[0] ? (i - 1) : ((holder + i) % NumPorts);
      if (!found && request[cand])
      begin
        nextState = '0;
        nextState[cand + 1] = 1'b1;
        found = 1'b1;
      end
    end
  end

endmodule

//--- logic/flitSwitch.sv
module flitSwitch (
  input  logic                        clk,
  input  logic                        rst,
  input  nocPkg::grant_t              grant,
  input  logic [nocPkg::NumPorts-1:0] notEmpty,
  input  nocPkg::flit_t               headFlit [nocPkg::NumPorts],
  output logic [nocPkg::NumPorts-1:0] pop,
  output nocPkg::linkFlit_t           linkOut,
  output logic                        linkValid
);

  localparam int NumPorts = nocPkg::NumPorts;

  nocPkg::linkFlit_t selected;
  logic              anyPop;

  // --------------------------------------------------
  // selection
  // --------------------------------------------------
  always_comb
  begin
    selected = '0;
    for (int p = 0; p < NumPorts; p++)
    begin
      pop[p] = grant[p + 1] && notEmpty[p];   // the grant alone does not pop an empty buffer.
      if (grant[p + 1])
      begin
        selected.srcPort = nocPkg::portId_t'(p);
        selected.flit = headFlit[p];
      end
    end
  end

  assign anyPop = |pop;

  // --------------------------------------------------
  // output link register
  // --------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      linkValid <= 1'b0;
    end
    else
    begin
      linkValid <= anyPop;
    end
  end

  always_ff @(posedge clk)
  begin
    if (anyPop)
    begin
      linkOut <= selected;   // holds the last flit while the link is quiet.
    end
  end

endmodule

//--- logic/outputPort.sv
module outputPort #(
  parameter int BufferDepth = 8
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [nocPkg::NumPorts-1:0] inValid,
  input  nocPkg::flit_t               inFlit [nocPkg::NumPorts],
  output logic [nocPkg::NumPorts-1:0] full,
  output nocPkg::linkFlit_t           linkOut,
  output logic                        linkValid
);

  localparam int NumPorts = nocPkg::NumPorts;

  nocPkg::flit_t       headFlit [NumPorts];
  logic [NumPorts-1:0] notEmpty;
  logic [NumPorts-1:0] pop;
  nocPkg::grant_t      grant;

  // --------------------------------------------------
  // input buffers, one per channel
  // --------------------------------------------------
  for (genvar p = 0; p < NumPorts; p++)
  begin : gBuffer
    inputBuffer #(
      .BufferDepth (BufferDepth)
    ) i_inputBuffer (
      .clk      (clk),
      .rst      (rst),
      .push     (inValid[p]),
      .inFlit   (inFlit[p]),
      .pop      (pop[p]),
      .headFlit (headFlit[p]),
      .notEmpty (notEmpty[p]),
      .full     (full[p])
    );
  end

  // --------------------------------------------------
  // link arbitration
  // --------------------------------------------------

  // a buffer with data is a request for the link.
  outputArbiter i_outputArbiter (
    .clk      (clk),
    .rst      (rst),
    .request  (notEmpty),
    .headFlit (headFlit),
    .grant    (grant)
  );

  flitSwitch i_flitSwitch (
    .clk       (clk),
    .rst       (rst),
    .grant     (grant),
    .notEmpty  (notEmpty),
    .headFlit  (headFlit),
    .pop       (pop),
    .linkOut   (linkOut),
    .linkValid (linkValid)
  );

endmodule

//--- verification/outputPort_tb.sv
module outputPort_tb;

  localparam int NumPorts = nocPkg::NumPorts;
  localparam int QuietCycles = 8;   // the link must stay silent this long after the last flit.

  logic                           clk;
  logic                           rst;
  logic [NumPorts-1:0]            inValid;
  nocPkg::flit_t                  inFlit [NumPorts];
  logic [NumPorts-1:0]            full;
  nocPkg::linkFlit_t              linkOut;
  logic                           linkValid;

  int                             stimCycle [$];
  int                             stimPort [$];
  nocPkg::flit_t                  stimFlit [$];
  int                             nextStim;
  int                             cycle;
  int                             timeoutCycle;
  int                             burstCycle;   // cycle where every channel gets a head.

  nocPkg::flit_t                  expFlit [NumPorts][$];
  int                             expCycle [NumPorts][$];
  logic [nocPkg::LengthWidth-1:0] lastLimit [NumPorts];
  nocPkg::portId_t                lastSrc;
  int                             runLen;
  int                             runBound;
  int                             orderIdx;
  int                             quiet;

  outputPort #(
    .BufferDepth (8)
  ) i_outputPort (
    .clk       (clk),
    .rst       (rst),
    .inValid   (inValid),
    .inFlit    (inFlit),
    .full      (full),
    .linkOut   (linkOut),
    .linkValid (linkValid)
  );

  always #2 clk = ~clk;

  // --------------------------------------------------
  // failure reporting and compares
  // --------------------------------------------------
  task automatic stopRun();
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic failRun(input string reason);
    $display("%0t: %s", $time, reason);
    stopRun();
  endtask

  task automatic reportMismatch(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
    $display("[FAIL] %0t %s expected %0h got %0h", $time, name, expected, actual);
    stopRun();
  endtask

  task automatic checkLinkFlit(input nocPkg::linkFlit_t expected,
                               input nocPkg::linkFlit_t actual);
    if (actual.srcPort !== expected.srcPort)
    begin
      reportMismatch("linkOut.srcPort", expected.srcPort, actual.srcPort);
    end
    if (actual.flit.kind !== expected.flit.kind)
    begin
      reportMismatch("linkOut.flit.kind", expected.flit.kind, actual.flit.kind);
    end
    if (actual.flit.length !== expected.flit.length)
    begin
      reportMismatch("linkOut.flit.length", expected.flit.length, actual.flit.length);
    end
    if (actual.flit.payload !== expected.flit.payload)
    begin
      reportMismatch("linkOut.flit.payload", expected.flit.payload, actual.flit.payload);
    end
  endtask

  task automatic checkSrcPort(input nocPkg::portId_t expected, input nocPkg::portId_t actual);
    if (actual !== expected)
    begin
      $display("[FAIL] %0t linkOut.srcPort expected %s got %s", $time, expected.name(),
               actual.name());
      stopRun();
    end
  endtask

  // --------------------------------------------------
  // testdata
  // --------------------------------------------------
  task automatic readTestdata();
    int            fd;
    int            fields;
    int            c;
    int            port;
    int            kind;
    int            len;
    int            payload;
    string         line;
    int            headsAt [int];
    nocPkg::flit_t flit;

    fd = $fopen("verification/outputPortTestdata.txt", "r");
    if (fd == 0)
    begin
      failRun("cannot open the testdata file");
    end
    while (!$feof(fd))
    begin
      line = "";
      void'($fgets(line, fd));
      fields = $sscanf(line, "%d %d %d %d %h", c, port, kind, len, payload);
      if (fields == 5)   // comment and blank lines do not parse.
      begin
        if (port < 0 || port >= NumPorts || kind < 1 || kind > 3)
        begin
          failRun("a testdata line has a bad channel or flit kind");
        end
        if (stimCycle.size() > 0 && c < stimCycle[$])
        begin
          failRun("testdata lines are not in cycle order");
        end
        flit.kind = nocPkg::flitKind_t'(3'(kind));
        flit.length = nocPkg::LengthWidth'(len);
        flit.payload = nocPkg::PayloadWidth'(payload);
        stimCycle.push_back(c);
        stimPort.push_back(port);
        stimFlit.push_back(flit);
        if (flit.kind == nocPkg::Head)
        begin
          headsAt[c] = headsAt.exists(c) ? headsAt[c] + 1 : 1;
        end
      end
    end
    $fclose(fd);
    if (stimCycle.size() == 0)
    begin
      failRun("the testdata file holds no flits");
    end
    foreach (headsAt[hc])
    begin
      if (burstCycle < 0 && headsAt[hc] == NumPorts)
      begin
        burstCycle = hc;
      end
    end
    if (burstCycle < 0)
    begin
      failRun("the testdata has no cycle with a head on every channel");
    end
    timeoutCycle = stimCycle[$] + 6 * stimCycle.size() + 100;
  endtask

  // --------------------------------------------------
  // scoreboard
  // --------------------------------------------------

  // true if a channel other than src had a flit in its buffer when the arbiter last decided.
  function automatic bit othersWaiting(input int src);
    bit waiting;

    waiting = 1'b0;
    for (int q = 0; q < NumPorts; q++)
    begin
      if (q != src && expCycle[q].size() > 0 && expCycle[q][0] <= cycle - 4)
      begin
        waiting = 1'b1;
      end
    end
    return waiting;
  endfunction

  function automatic bit allDelivered();
    bit done;

    done = (nextStim == stimCycle.size());
    for (int p = 0; p < NumPorts; p++)
    begin
      if (expFlit[p].size() != 0)
      begin
        done = 1'b0;
      end
    end
    return done;
  endfunction

  task automatic scoreLinkFlit(input nocPkg::linkFlit_t got);
    int                src;
    int                owner;
    nocPkg::linkFlit_t expected;

    if ($isunknown(got))
    begin
      failRun("linkOut has unknown bits while linkValid is high");
    end
    src = int'(got.srcPort);

    // the sending channel is the one whose oldest pending flit this is.
    owner = -1;
    for (int q = 0; q < NumPorts; q++)
    begin
      if (expFlit[q].size() > 0 && expFlit[q][0] === got.flit && (owner < 0 || q == src))
      begin
        owner = q;
      end
    end
    if (owner < 0)
    begin
      if (src >= NumPorts)
      begin
        failRun("a link flit carries an unknown source port");
      end
      owner = src;   // with no matching head the tagged channel is compared field by field.
    end
    if (expFlit[owner].size() == 0)
    begin
      failRun("flit left a channel with nothing expected");
    end
    expected.srcPort = nocPkg::portId_t'(owner);
    expected.flit = expFlit[owner].pop_front();
    void'(expCycle[owner].pop_front());
    checkLinkFlit(expected, got);

    // after the idle burst each new owner must follow L, N, E, W, S.
    if (cycle > burstCycle && orderIdx < NumPorts && (orderIdx == 0 || got.srcPort != lastSrc))
    begin
      checkSrcPort(nocPkg::portId_t'(orderIdx), got.srcPort);
      orderIdx++;
    end

    if (got.flit.kind == nocPkg::Head)
    begin
      lastLimit[src] = got.flit.length;
    end
    if (runLen == 0 || got.srcPort != lastSrc)
    begin
      runLen = 1;
      runBound = int'(lastLimit[src]);
    end
    else
    begin
      runLen++;
      if (int'(lastLimit[src]) > runBound)
      begin
        runBound = int'(lastLimit[src]);
      end
    end
    if (runLen > runBound + 1 && othersWaiting(src))
    begin
      failRun("a channel kept the link past its hold limit while others waited");
    end
    lastSrc = got.srcPort;
  endtask

  task automatic endRun();
    if (orderIdx == NumPorts)
    begin
      $display("TEST PASS");
      $finish;
    end
    else
    begin
      failRun("the rotating grant order after the idle burst was not seen");
    end
  endtask

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------
  initial
  begin
    clk = 1'b0;
    rst = 1'b1;
    inValid = '0;
    for (int p = 0; p < NumPorts; p++)
    begin
      inFlit[p] = '0;
      lastLimit[p] = '0;   // the hold limit is zero out of reset.
    end
    nextStim = 0;
    cycle = 0;
    runLen = 0;
    runBound = 0;
    orderIdx = 0;
    quiet = 0;
    burstCycle = -1;
    lastSrc = nocPkg::Local;
    readTestdata();
    repeat (16) @(posedge clk);
    rst <= 1'b0;
  end

  always @(posedge clk)
  begin
    if (rst)
    begin
      cycle <= 0;
    end
    else
    begin
      inValid <= '0;
      while (nextStim < stimCycle.size() && stimCycle[nextStim] == cycle)
      begin
        inValid[stimPort[nextStim]] <= 1'b1;
        inFlit[stimPort[nextStim]] <= stimFlit[nextStim];
        expFlit[stimPort[nextStim]].push_back(stimFlit[nextStim]);
        expCycle[stimPort[nextStim]].push_back(cycle);
        nextStim++;
      end
      cycle <= cycle + 1;
    end
  end

  // --------------------------------------------------
  // monitor, sampled mid-cycle
  // --------------------------------------------------
  always @(negedge clk)
  begin
    if (rst)
    begin
      if (linkValid !== 1'b0)
      begin
        failRun("linkValid is not low during reset");
      end
      if (full !== '0)
      begin
        failRun("an input buffer reports full during reset");
      end
    end
    else
    begin
      for (int p = 0; p < NumPorts; p++)
      begin
        if (inValid[p] && full[p])
        begin
          failRun("a flit was offered to a full input buffer");
        end
      end
      if ($isunknown(linkValid))
      begin
        failRun("linkValid is unknown after reset");
      end
      if (linkValid)
      begin
        scoreLinkFlit(linkOut);
        quiet = 0;
      end
      else
      begin
        runLen = 0;   // a quiet cycle ends any run.
        if (allDelivered())
        begin
          quiet++;
        end
      end
      if (quiet >= QuietCycles)
      begin
        endRun();
      end
      else if (cycle > timeoutCycle)
      begin
        failRun("delivery did not finish before the cycle limit");
      end
    end
  end

endmodule

//--- outputPort.f
logic/nocPkg.sv
logic/inputBuffer.sv
logic/holdTimer.sv
logic/outputArbiter.sv
logic/flitSwitch.sv
logic/outputPort.sv
verification/outputPort_tb.sv

//--- Bender.yml
package:
  name: outputPort

sources:
  # package first, then the design from the leaves up.
  - files:
      - logic/nocPkg.sv
      - logic/inputBuffer.sv
      - logic/holdTimer.sv
      - logic/outputArbiter.sv
      - logic/flitSwitch.sv
      - logic/outputPort.sv

  - target: test
    files:
      - verification/outputPort_tb.sv

//--- verification/outputPortTestdata.txt
# columns: cycle channel kind length payload(hex), cycle counts from the end of reset
# channel 0..4 = Local North East West South, kind 1 head 2 body 3 tail
# one packet on North alone
4 1 1 3 a101
5 1 2 0 a102
6 1 3 0 a103
# idle link, then a head on every channel in the same cycle
20 0 1 1 b001
20 1 1 1 b101
20 2 1 1 b201
20 3 1 1 b301
20 4 1 1 b401
21 0 2 0 b002
21 1 2 0 b102
21 2 2 0 b202
21 3 2 0 b302
21 4 2 0 b402
22 0 3 0 b003
22 1 3 0 b103
22 2 3 0 b203
22 3 3 0 b303
22 4 3 0 b403
# interleaved packets with mixed hold limits
50 0 1 2 c001
50 4 1 4 c401
51 0 2 0 c002
51 2 1 0 c201
52 0 2 0 c003
52 2 2 0 c202
52 3 1 2 c301
52 4 2 0 c402
53 0 2 0 c004
53 1 1 1 c101
53 2 3 0 c203
53 3 2 0 c302
54 0 3 0 c005
54 1 2 0 c102
54 4 2 0 c403
55 1 3 0 c103
55 3 2 0 c303
56 4 3 0 c404
57 3 3 0 c304
